// File: eth_readout.f
verilog/readout_pkg.sv
verilog/sync_fifo.sv
verilog/frame_seq.sv
verilog/frame_builder.sv
verilog/eth_readout.sv
verif/eth_readout_sva.sv
verif/eth_readout_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the eth_readout testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module eth_readout_tb \
	-f eth_readout.f -Mdir obj_dir -o eth_readout_sim > build.log 2>&1 \
	&& ./obj_dir/eth_readout_sim > sim.log 2>&1 \
	|| { cat build.log; echo "simulation did not complete" >> sim.log; }
cat sim.log
grep -q "test passed" sim.log && ! grep -q "test failed" sim.log && echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: verif/eth_readout_tb.sv
`timescale 1ns/10ps
module eth_readout_tb;
	import readout_pkg::*;

	localparam int SAMPLES_PER_EVT = 8;
	localparam int AMT_LEVEL = 4;
	localparam int AFL_LEVEL = 28;
	localparam int FRAME_WORDS = HDR_WORDS + SAMPLES_PER_EVT + TRL_WORDS;
	localparam int MAX_CYCLES = 4000; // Tests need about 400 cycles

	logic RCLK;
	logic RST_RESYNC;
	logic smp_wr_en_i;
	sample_t smp_data_i;
	logic smp_ovlp_i;
	logic l1a_wr_en_i;
	l1a_num_t l1a_num_i;
	logic warn_i;
	logic txack_i;
	tx_word_t txd_o;
	logic txd_valid_o;
	logic evt_buf_amt_o;
	logic evt_buf_afl_o;

	tx_word_t exp_q[$]; // Expected frame words in order
	logic [15:0] lfsr = 16'd13305;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int words = 0;

	eth_readout #(
		.SAMPLES_PER_EVT(SAMPLES_PER_EVT),
		.AMT_LEVEL(AMT_LEVEL),
		.AFL_LEVEL(AFL_LEVEL)
	) uut (.*);

	initial begin
		RCLK = 1'b0;
		forever #5 RCLK = ~RCLK;
	end

	always @(posedge RCLK) cycles <= cycles + 1;

	initial begin
		wait (cycles >= MAX_CYCLES);
		$display("Timeout after %0d cycles with %0d words outstanding", cycles, exp_q.size());
		$display("test failed");
		$finish;
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		repeat (n) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Compare every transmitted word with the model
	always @(negedge RCLK) begin
		if (txd_valid_o) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("Word %h appeared on txd_o with no frame pending", txd_o);
				errors++;
			end
			if (exp_q.size() != 0) begin
				assert (txd_o == exp_q[0]) else begin
					$display("FAILED txd_o slot %0d: got %h, expected %h",
						words % FRAME_WORDS, txd_o, exp_q[0]);
					errors++;
				end
				void'(exp_q.pop_front());
			end
			words++;
		end
	end

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		assert (got == exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Queue k triggers and their samples while txack_i is low
	task automatic load_events(input int k);
		crc_t crc;
		int e;
		for (e = 0; e < k; e++) begin
			@(posedge RCLK);
			#1;
			l1a_wr_en_i = 1'b1;
			l1a_num_i = l1a_num_t'(rand_bits(24));
			warn_i = 1'(rand_bits(1));
			exp_q.push_back({4'h0, l1a_num_i[23:12]});
			exp_q.push_back({4'h0, l1a_num_i[11:0]});
			crc = crc15_d13({1'b0, l1a_num_i[23:12]}, '0);
			crc = crc15_d13({1'b0, l1a_num_i[11:0]}, crc);
			repeat (SAMPLES_PER_EVT) begin
				@(posedge RCLK);
				#1;
				l1a_wr_en_i = 1'b0;
				smp_wr_en_i = 1'b1;
				smp_data_i = sample_t'(rand_bits(12));
				smp_ovlp_i = 1'(rand_bits(1));
				exp_q.push_back({1'b0, ~smp_ovlp_i, 2'b00, smp_data_i});
				crc = crc15_d13({1'b0, smp_data_i}, crc);
			end
			@(posedge RCLK);
			#1;
			smp_wr_en_i = 1'b0;
			exp_q.push_back({1'b0, crc});
			exp_q.push_back(MARKER_WORD);
			exp_q.push_back({STATUS_NIBBLE, l1a_num_i[5:0], occ_t'(k - e), warn_i}); // Before pop
			exp_q.push_back(CLOSE_WORD);
		end
	endtask

	task automatic run_test(input int num, input string name, input int k, input logic rnd_ack);
		int err0;
		int words0;
		err0 = errors;
		words0 = words;
		load_events(k);
		while (exp_q.size() != 0) begin
			@(posedge RCLK);
			#1;
			txack_i = rnd_ack ? 1'(rand_bits(1)) : 1'b1;
		end
		txack_i = 1'b0;
		$display("Test %0d %s: %0d words, %0d errors", num, name, words - words0, errors - err0);
	endtask

	// Sample buffer fills with no trigger queued, so nothing is read
	task automatic fill_flags();
		int err0;
		int n;
		err0 = errors;
		check_flag("evt_buf_amt_o", evt_buf_amt_o, 1'b1);
		smp_wr_en_i = 1'b1;
		smp_ovlp_i = 1'b0;
		for (n = 1; n <= AFL_LEVEL; n++) begin
			smp_data_i = sample_t'(rand_bits(12));
			@(posedge RCLK);
			#1;
			check_flag("evt_buf_amt_o", evt_buf_amt_o, n <= AMT_LEVEL); // n samples held
			check_flag("evt_buf_afl_o", evt_buf_afl_o, n >= AFL_LEVEL);
		end
		smp_wr_en_i = 1'b0;
		$display("Test 6 buffer flags: %0d samples, %0d errors", AFL_LEVEL, errors - err0);
	endtask

	initial begin
		RST_RESYNC = 1'b1;
		smp_wr_en_i = 1'b0;
		smp_data_i = '0;
		smp_ovlp_i = 1'b0;
		l1a_wr_en_i = 1'b0;
		l1a_num_i = '0;
		warn_i = 1'b0;
		txack_i = 1'b0;
		repeat (4) @(posedge RCLK);
		#1;
		RST_RESYNC = 1'b0;
		check_flag("evt_buf_amt_o", evt_buf_amt_o, 1'b1);
		check_flag("evt_buf_afl_o", evt_buf_afl_o, 1'b0);
		run_test(1, "header words", 1, 1'b0);
		run_test(2, "sample words", 1, 1'b0);
		run_test(3, "crc and trailer words", 1, 1'b0);
		run_test(4, "status occupancy", 3, 1'b0);
		run_test(5, "back-pressure", 3, 1'b1);
		fill_flags();
		$display("Summary: 6 tests, %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verif/eth_readout_sva.sv
`timescale 1ns/10ps
module eth_readout_sva #(
	parameter int SAMPLES_PER_EVT = 8
)(
	input  logic                  RCLK,
	input  logic                  RST_RESYNC,
	input  logic                  txack_i,
	input  readout_pkg::tx_word_t txd_i,
	input  logic                  txd_valid_i
);

	import readout_pkg::*;

	localparam int FRAME_WORDS = HDR_WORDS + SAMPLES_PER_EVT + TRL_WORDS;

	tx_word_t prev1;
	tx_word_t prev2;
	int word_idx;

	// Last two valid words and the position in the frame
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			prev1 <= '0;
			prev2 <= '0;
			word_idx <= 0;
		end else if (txd_valid_i) begin
			prev1 <= txd_i;
			prev2 <= prev1;
			word_idx <= (word_idx == FRAME_WORDS - 1) ? 0 : word_idx + 1;
		end
	end

	a_no_valid_in_reset: assert property (@(posedge RCLK) RST_RESYNC |-> !txd_valid_i)
		else $error("txd_valid_o high while reset is active");

	a_no_valid_after_stall: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		!txack_i |=> !txd_valid_i)
		else $error("txd_valid_o high in the cycle after txack_i was low");

	a_close_after_marker: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		(txd_valid_i && word_idx == FRAME_WORDS - 1) |->
		(txd_i == CLOSE_WORD && prev2 == MARKER_WORD))
		else $error("Closing word not preceded by the marker two words earlier");

endmodule

bind eth_readout eth_readout_sva #(
	.SAMPLES_PER_EVT(SAMPLES_PER_EVT)
) sva_i (
	.RCLK(RCLK),
	.RST_RESYNC(RST_RESYNC),
	.txack_i(txack_i),
	.txd_i(txd_o),
	.txd_valid_i(txd_valid_o)
);

// File: verilog/eth_readout.sv
`timescale 1ns/10ps
module eth_readout #(
	parameter int SAMPLES_PER_EVT = 8,
	parameter int SMP_DEPTH_LOG2 = 5,
	parameter int L1A_DEPTH_LOG2 = 4,
	parameter int AMT_LEVEL = 4,
	parameter int AFL_LEVEL = 28
)(
	input  logic                  RCLK,
	input  logic                  RST_RESYNC,
	input  logic                  smp_wr_en_i,
	input  readout_pkg::sample_t  smp_data_i,
	input  logic                  smp_ovlp_i,
	input  logic                  l1a_wr_en_i,
	input  readout_pkg::l1a_num_t l1a_num_i,
	input  logic                  warn_i,
	input  logic                  txack_i,
	output readout_pkg::tx_word_t txd_o,
	output logic                  txd_valid_o,
	output logic                  evt_buf_amt_o,
	output logic                  evt_buf_afl_o
);

	import readout_pkg::*;

	logic [SMP_DEPTH_LOG2:0] smp_count;
	logic [L1A_DEPTH_LOG2:0] l1a_count;
	sample_t smp_head_data;
	logic smp_head_ovlp;
	l1a_num_t l1a_head_num;
	logic l1a_head_warn;
	logic adv;
	slot_t slot;
	logic first_slot;
	logic smp_rd;
	logic l1a_rd;

	sync_fifo #(
		.WIDTH(13),
		.DEPTH_LOG2(SMP_DEPTH_LOG2),
		.AMT_LEVEL(AMT_LEVEL),
		.AFL_LEVEL(AFL_LEVEL)
	) smp_fifo (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.wr_en_i(smp_wr_en_i),
		.din_i({smp_ovlp_i, smp_data_i}),
		.rd_en_i(smp_rd),
		.dout_o({smp_head_ovlp, smp_head_data}),
		.count_o(smp_count),
		.amt_o(evt_buf_amt_o),
		.afl_o(evt_buf_afl_o)
	);

	sync_fifo #(
		.WIDTH(25),
		.DEPTH_LOG2(L1A_DEPTH_LOG2),
		.AMT_LEVEL(0),
		.AFL_LEVEL(2**L1A_DEPTH_LOG2)
	) l1a_fifo (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.wr_en_i(l1a_wr_en_i),
		.din_i({warn_i, l1a_num_i}),
		.rd_en_i(l1a_rd),
		.dout_o({l1a_head_warn, l1a_head_num}),
		.count_o(l1a_count), // Also the status occupancy
		.amt_o(),
		.afl_o()
	);

	frame_seq #(
		.SAMPLES_PER_EVT(SAMPLES_PER_EVT),
		.SMP_DEPTH_LOG2(SMP_DEPTH_LOG2),
		.L1A_DEPTH_LOG2(L1A_DEPTH_LOG2)
	) seq_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.smp_count_i(smp_count),
		.l1a_count_i(l1a_count),
		.txack_i(txack_i),
		.adv_o(adv),
		.slot_o(slot),
		.first_slot_o(first_slot),
		.smp_rd_o(smp_rd),
		.l1a_rd_o(l1a_rd)
	);

	frame_builder #(
		.SAMPLES_PER_EVT(SAMPLES_PER_EVT)
	) bld_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.txack_i(txack_i),
		.adv_i(adv),
		.slot_i(slot),
		.first_slot_i(first_slot),
		.l1a_num_i(l1a_head_num),
		.warn_i(l1a_head_warn),
		.l1a_occ_i(occ_t'(l1a_count)),
		.smp_data_i(smp_head_data),
		.smp_ovlp_i(smp_head_ovlp),
		.txd_o(txd_o),
		.txd_valid_o(txd_valid_o)
	);

endmodule

// File: verilog/frame_builder.sv
`timescale 1ns/10ps
module frame_builder #(
	parameter int SAMPLES_PER_EVT = 8
)(
	input  logic                  RCLK,
	input  logic                  RST_RESYNC,
	input  logic                  txack_i,
	input  logic                  adv_i,
	input  readout_pkg::slot_t    slot_i,
	input  logic                  first_slot_i,
	input  readout_pkg::l1a_num_t l1a_num_i,
	input  logic                  warn_i,
	input  readout_pkg::occ_t     l1a_occ_i,
	input  readout_pkg::sample_t  smp_data_i,
	input  logic                  smp_ovlp_i,
	output readout_pkg::tx_word_t txd_o,
	output logic                  txd_valid_o
);

	import readout_pkg::*;

	localparam slot_t HDR_LOW = slot_t'(HDR_WORDS - 1);
	localparam slot_t TRL_CRC = slot_t'(HDR_WORDS + SAMPLES_PER_EVT);
	localparam slot_t TRL_MARK = slot_t'(HDR_WORDS + SAMPLES_PER_EVT + 1);
	localparam slot_t TRL_STAT = slot_t'(HDR_WORDS + SAMPLES_PER_EVT + 2);
	localparam slot_t TRL_CLOSE = slot_t'(HDR_WORDS + SAMPLES_PER_EVT + 3);

	tx_word_t word1;
	slot_t slot1;
	crc_t crc;
	logic valid1;

	// Stage 1 word format
	always_ff @(posedge RCLK) begin
		if (adv_i) begin
			slot1 <= slot_i;
			if (slot_i == '0) begin
				word1 <= {4'h0, l1a_num_i[23:12]};
			end else if (slot_i == HDR_LOW) begin
				word1 <= {4'h0, l1a_num_i[11:0]};
			end else begin
				word1 <= {1'b0, ~smp_ovlp_i, 2'b00, smp_data_i};
			end
			// CRC trails the word register by one slot
			if (first_slot_i) begin
				crc <= '0;
			end else begin
				crc <= crc15_d13(crc_data_t'(word1[12:0]), crc);
			end
		end
	end

	// Stage 2 trailer insertion
	always_ff @(posedge RCLK) begin
		if (txack_i) begin
			case (slot1)
				TRL_CRC:   txd_o <= {1'b0, crc};
				TRL_MARK:  txd_o <= MARKER_WORD;
				TRL_STAT:  txd_o <= {STATUS_NIBBLE, l1a_num_i[5:0], l1a_occ_i, warn_i};
				TRL_CLOSE: txd_o <= CLOSE_WORD;
				default:   txd_o <= word1;
			endcase
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid1 <= 1'b0;
			txd_valid_o <= 1'b0;
		end else if (txack_i) begin
			valid1 <= adv_i;
			txd_valid_o <= valid1;
		end else begin
			txd_valid_o <= 1'b0; // Word already shown, hold data only
		end
	end

endmodule

// File: verilog/frame_seq.sv
`timescale 1ns/10ps
module frame_seq #(
	parameter int SAMPLES_PER_EVT = 8,
	parameter int SMP_DEPTH_LOG2 = 5,
	parameter int L1A_DEPTH_LOG2 = 4
)(
	input  logic                      RCLK,
	input  logic                      RST_RESYNC,
	input  logic [SMP_DEPTH_LOG2:0]   smp_count_i,
	input  logic [L1A_DEPTH_LOG2:0]   l1a_count_i,
	input  logic                      txack_i,
	output logic                      adv_o,
	output readout_pkg::slot_t        slot_o,
	output logic                      first_slot_o,
	output logic                      smp_rd_o,
	output logic                      l1a_rd_o
);

	import readout_pkg::*;

	localparam slot_t SMP_FIRST = slot_t'(HDR_WORDS);
	localparam slot_t SMP_END = slot_t'(HDR_WORDS + SAMPLES_PER_EVT);
	localparam slot_t LAST_SLOT = slot_t'(HDR_WORDS + SAMPLES_PER_EVT + TRL_WORDS - 1);

	seq_state_t state;
	seq_state_t state_nxt;
	slot_t slot;
	logic start;
	logic last;

	// A trigger is queued and its samples are all buffered
	assign start = (l1a_count_i != '0) && (smp_count_i >= SAMPLES_PER_EVT);
	assign last = (slot == LAST_SLOT);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) state_nxt = SEND;
			end
			SEND: begin
				if (adv_o && last) state_nxt = DONE;
			end
			DONE: begin
				state_nxt = IDLE; // Trigger popped here
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= IDLE;
			slot <= '0;
		end else begin
			state <= state_nxt;
			if (state != SEND) begin
				slot <= '0;
			end else if (adv_o) begin
				slot <= slot + 1'b1;
			end
		end
	end

	// One slot per cycle with transmitter ack
	assign adv_o = (state == SEND) && txack_i;
	assign slot_o = slot;
	assign first_slot_o = (slot == '0);
	assign smp_rd_o = adv_o && (slot >= SMP_FIRST) && (slot < SMP_END);
	assign l1a_rd_o = (state == DONE);

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/10ps
module sync_fifo #(
	parameter int WIDTH = 13,
	parameter int DEPTH_LOG2 = 5,
	parameter int AMT_LEVEL = 4,
	parameter int AFL_LEVEL = 28
)(
	input  logic                  RCLK,
	input  logic                  RST_RESYNC,
	input  logic                  wr_en_i,
	input  logic [WIDTH-1:0]      din_i,
	input  logic                  rd_en_i,
	output logic [WIDTH-1:0]      dout_o,
	output logic [DEPTH_LOG2:0]   count_o,
	output logic                  amt_o,
	output logic                  afl_o
);

	localparam int DEPTH = 2**DEPTH_LOG2;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count_o == DEPTH);
	assign do_rd = rd_en_i && (count_o != '0);
	assign do_wr = wr_en_i && (!full || do_rd); // Dropped when full

	always_ff @(posedge RCLK) begin
		if (do_wr) begin
			mem[wr_ptr] <= din_i;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count_o <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count_o <= count_o + 1'b1;
				2'b01: count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

	assign dout_o = mem[rd_ptr]; // Head word, show-ahead
	assign amt_o = (count_o <= AMT_LEVEL);
	assign afl_o = (count_o >= AFL_LEVEL);

endmodule

// File: verilog/readout_pkg.sv
package readout_pkg;

	typedef logic [11:0] sample_t;
	typedef logic [23:0] l1a_num_t;
	typedef logic [15:0] tx_word_t;
	typedef logic [14:0] crc_t;
	typedef logic [12:0] crc_data_t;
	typedef logic [4:0]  occ_t;
	typedef logic [6:0]  slot_t;

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		DONE
	} seq_state_t;

	localparam tx_word_t MARKER_WORD = 16'h700C;
	localparam tx_word_t CLOSE_WORD = 16'h7FFF;
	localparam logic [3:0] STATUS_NIBBLE = 4'h7;
	localparam int HDR_WORDS = 2; // Trigger number high, low
	localparam int TRL_WORDS = 4; // CRC, marker, status, close

	// One CRC-15 step over 13 data bits
	function automatic crc_t crc15_d13(input crc_data_t d, input crc_t c);
		crc_t n;
		int i;
		n[0] = d[0] ^ c[2];
		for (i = 1; i <= 12; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage
